//--- tests/arbitrated_mem_golden.txt
// Batch: a count, then count commands as client op addr data (op 0 read, 1 write, 2 add),
// then count responses as client rdata in arrival order; a count of 0 ends the file
// All four read right after reset, highest client first
4
0 0 0 00000000
1 0 1 00000000
2 0 2 00000000
3 0 3 00000000
3 00000000
2 00000000
1 00000000
0 00000000
// Lone read of an untouched word
1
1 0 5 00000000
1 00000000
// Same client again at once, write returns the old word
1
1 1 3 deadbeef
1 00000000
// Read back the written word
1
2 0 3 deadbeef
2 deadbeef
// Client 2 won last, so adds go 0, 3, 2 and wrap past 2 to the 32
3
3 2 3 00000005
2 2 3 fffffffe
0 2 3 21524111
0 00000000
3 00000005
2 00000003
// Overwrite returns the accumulated word
1
3 1 3 12345678
3 00000003
1
0 0 3 12345678
0 12345678
// Add to zero returns the new word
1
2 2 9 80000001
2 80000001
// Client 1 sits below last winner 2, so it goes before 3
2
1 0 9 00000000
3 2 9 80000000
1 80000001
3 00000001
0

//--- arbitrated_mem.f
logic/mem_arb_pkg.sv
logic/leading_one_detector.sv
logic/round_robin_arbiter.sv
logic/request_holder.sv
logic/mem_executor.sv
logic/arbitrated_mem.sv
tests/arbitrated_mem_tb.sv

//--- Bender.yml
package:
  name: arbitrated_mem

sources:
  # Package first, then leaf modules up to the top level
  - logic/mem_arb_pkg.sv
  - logic/leading_one_detector.sv
  - logic/round_robin_arbiter.sv
  - logic/request_holder.sv
  - logic/mem_executor.sv
  - logic/arbitrated_mem.sv

  # Testbench, reads tests/arbitrated_mem_golden.txt at run time
  - target: test
    files:
      - tests/arbitrated_mem_tb.sv

//--- tests/arbitrated_mem_tb.sv
`timescale 1ns/1ns
`default_nettype none

// Testbench for the arbitrated memory port, driven batch by batch from the golden file
module arbitrated_mem_tb;

    import mem_arb_pkg::*;

    // ========================================================================
    // DUT connections and bookkeeping
    // ========================================================================

    logic                       clk;
    logic                       rst_n;
    logic [num_clients-1:0]     req_valid;
    mem_cmd_t [num_clients-1:0] req_cmd;
    logic                       rsp_valid;
    mem_rsp_t                   rsp;

    // Golden words with counts, commands and expected responses in file order
    logic [31:0] golden_mem [0:255];

    int error_count;
    int timeout_count;
    int batch_num;
    int ptr;
    bit aborted;

    // Response pulses seen on the port and responses the golden file asks for
    int rsp_seen;
    int rsp_expected;

    arbitrated_mem dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_cmd   (req_cmd),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    // 100 ns period
    initial
    begin
        clk = 1'b0;
        forever
        begin
            #50 clk = ~clk;
        end
    end

    // Every response pulse, expected or not
    always @(negedge clk)
    begin
        if (rsp_valid === 1'b1)
        begin
            rsp_seen++;
        end
    end

    // ========================================================================
    // Stimulus and checking
    // ========================================================================

    // Strobe every command of a batch in the same cycle
    // Each command takes four golden words for client, op, addr and data
    task automatic drive_strobes(input int base, input int count);
        int c;
        @(posedge clk);
        #10;
        for (int i = 0; i < count; i++)
        begin
            c = int'(golden_mem[base + 4 * i][client_w-1:0]);
            req_valid[c]    = 1'b1;
            req_cmd[c].op   = mem_op_e'(golden_mem[base + 4 * i + 1][1:0]);
            req_cmd[c].addr = golden_mem[base + 4 * i + 2][addr_w-1:0];
            req_cmd[c].data = golden_mem[base + 4 * i + 3];
        end
        // This edge samples the strobes
        @(posedge clk);
        #10;
        req_valid = '0;
        req_cmd   = '0;
    endtask

    // Sample on falling edges, where registered outputs are settled
    task automatic wait_response(output int cycles, output bit found);
        cycles = 0;
        found  = 1'b0;
        while (!found && cycles < 40)
        begin
            @(negedge clk);
            cycles++;
            if (rsp_valid === 1'b1)
            begin
                found = 1'b1;
            end
        end
    endtask

    // Compare both response fields against the golden pair
    task automatic check_response(input logic [31:0] exp_client, input logic [31:0] exp_rdata);
        if (rsp.client !== exp_client[client_w-1:0])
        begin
            $display("[ERROR] rsp.client batch %0d: expected %h, got %h",
                     batch_num, exp_client[client_w-1:0], rsp.client);
            error_count++;
        end
        if (rsp.rdata !== exp_rdata)
        begin
            $display("[ERROR] rsp.rdata batch %0d: expected %h, got %h",
                     batch_num, exp_rdata, rsp.rdata);
            error_count++;
        end
    endtask

    // One batch: strobe, then collect the responses in arrival order
    task automatic run_batch();
        int count;
        int exp_base;
        int waited;
        bit found;
        count    = int'(golden_mem[ptr]);
        exp_base = ptr + 1 + 4 * count;
        if (count > num_clients || count < 0)
        begin
            $display("Batch %0d asks for %0d commands, more than there are clients",
                     batch_num, count);
            error_count++;
            aborted = 1'b1;
            return;
        end
        drive_strobes(ptr + 1, count);
        rsp_expected += count;
        for (int k = 0; k < count; k++)
        begin
            wait_response(waited, found);
            if (!found)
            begin
                $display("Timed out waiting for response %0d of batch %0d from client %0d",
                         k, batch_num, golden_mem[exp_base + 2 * k]);
                timeout_count++;
                aborted = 1'b1;
                break;
            end
            // First answer three cycles after the strobe edge, the rest back to back
            if (k == 0 && waited != 3)
            begin
                $display("Batch %0d first response came %0d cycles after the strobe, not 3",
                         batch_num, waited);
                error_count++;
            end
            if (k > 0 && waited != 1)
            begin
                $display("Batch %0d response %0d came %0d cycles after the previous one",
                         batch_num, k, waited);
                error_count++;
            end
            check_response(golden_mem[exp_base + 2 * k], golden_mem[exp_base + 2 * k + 1]);
        end
        ptr = exp_base + 2 * count;
        batch_num++;
    endtask

    // ========================================================================
    // Main sequence
    // ========================================================================

    initial
    begin
        rst_n         = 1'b0;
        req_valid     = '0;
        req_cmd       = '0;
        error_count   = 0;
        timeout_count = 0;
        batch_num     = 0;
        ptr           = 0;
        aborted       = 1'b0;
        rsp_seen      = 0;
        rsp_expected  = 0;

        $readmemh("tests/arbitrated_mem_golden.txt", golden_mem);
        if (golden_mem[0] === 'x)
        begin
            $display("Golden file could not be read or is empty");
            error_count++;
            aborted = 1'b1;
        end

        // Reset held for five cycles, released off the edge
        repeat (5) @(posedge clk);
        #10;
        rst_n = 1'b1;

        // A count of zero ends the stimulus
        while (!aborted && ptr < 240 && golden_mem[ptr] !== 32'd0)
        begin
            if (golden_mem[ptr] === 'x)
            begin
                $display("Golden file ends without a closing zero count");
                error_count++;
                aborted = 1'b1;
            end
            else
            begin
                run_batch();
            end
        end

        // Give a stray response time to show up before counting
        repeat (4) @(posedge clk);
        if (!aborted && rsp_seen != rsp_expected)
        begin
            $display("Saw %0d response pulses where %0d responses were expected",
                     rsp_seen, rsp_expected);
            error_count++;
        end

        $display("Ran %0d batches: %0d errors, %0d timeouts",
                 batch_num, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0)
        begin
            $display("Everything OK");
        end
        else
        begin
            $display("Something failed");
        end
        $finish;
    end

endmodule : arbitrated_mem_tb

`default_nettype wire

//--- logic/arbitrated_mem.sv
`timescale 1ns/1ns
`default_nettype none

// Four clients sharing one memory through a round-robin arbiter
module arbitrated_mem (
    input  wire                                                 clk,
    input  wire                                                 rst_n,
    input  wire  [mem_arb_pkg::num_clients-1:0]                 req_valid,
    input  wire  mem_arb_pkg::mem_cmd_t [mem_arb_pkg::num_clients-1:0] req_cmd,
    output logic                                                rsp_valid,
    output mem_arb_pkg::mem_rsp_t                               rsp
);

    import mem_arb_pkg::*;

    // Pending requests without the current grant
    logic [num_clients-1:0] req;
    // Registered one-hot grant
    logic [num_clients-1:0] gnt;

    // Granted command toward the memory
    logic                   gnt_valid;
    logic [client_w-1:0]    gnt_client;
    mem_cmd_t               gnt_cmd;

    // Strobes in, pending flags out
    request_holder holder_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_cmd    (req_cmd),
        .gnt        (gnt),
        .req        (req),
        .gnt_valid  (gnt_valid),
        .gnt_client (gnt_client),
        .gnt_cmd    (gnt_cmd)
    );

    round_robin_arbiter #(
        .clients (num_clients)
    ) arbiter_i (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .gnt   (gnt)
    );

    // Executes in the grant cycle, answers one edge later
    mem_executor executor_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .gnt_valid  (gnt_valid),
        .gnt_client (gnt_client),
        .gnt_cmd    (gnt_cmd),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp)
    );

endmodule : arbitrated_mem

`default_nettype wire

//--- logic/mem_executor.sv
`timescale 1ns/1ns
`default_nettype none

// Shared memory that executes the granted command
module mem_executor (
    input  wire                               clk,
    input  wire                               rst_n,
    input  wire                               gnt_valid,
    input  wire  [mem_arb_pkg::client_w-1:0]  gnt_client,
    input  wire  mem_arb_pkg::mem_cmd_t       gnt_cmd,
    output logic                              rsp_valid,
    output mem_arb_pkg::mem_rsp_t             rsp
);

    import mem_arb_pkg::*;

    // ========================================================================
    // Storage and datapath
    // ========================================================================

    logic [data_w-1:0] mem_q [mem_depth];

    // Word currently at the command address
    logic [data_w-1:0] old_word;
    // Wraps modulo 2 to the 32
    logic [data_w-1:0] sum_word;
    // Value written back and value returned
    logic [data_w-1:0] new_word;
    logic [data_w-1:0] rsp_data;
    logic              mem_we;

    assign old_word = mem_q[gnt_cmd.addr];
    assign sum_word = old_word + gnt_cmd.data;

    // Opcode decode
    always_comb
    begin
        mem_we   = 1'b0;
        new_word = old_word;
        rsp_data = old_word;
        case (gnt_cmd.op)
            op_read:
            begin
                rsp_data = old_word;
            end
            op_write:
            begin
                mem_we   = gnt_valid;
                new_word = gnt_cmd.data;
            end
            op_add:
            begin
                mem_we   = gnt_valid;
                new_word = sum_word;
                rsp_data = sum_word;
            end
            default:
            begin
                mem_we = 1'b0;
            end
        endcase
    end

    // Memory comes out of reset all zeros
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < mem_depth; i++)
            begin
                mem_q[i] <= '0;
            end
        end
        else if (mem_we)
        begin
            mem_q[gnt_cmd.addr] <= new_word;
        end
    end

    // ========================================================================
    // Response
    // ========================================================================

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rsp_valid <= 1'b0;
        end
        else
        begin
            rsp_valid <= gnt_valid;
        end
    end

    // Payload only meaningful with rsp_valid
    always_ff @(posedge clk)
    begin
        if (gnt_valid)
        begin
            rsp.client <= gnt_client;
            rsp.rdata  <= rsp_data;
        end
    end

    // Holder only forwards commands with a known opcode
    op_defined_a : assert property (@(posedge clk) disable iff (!rst_n)
        gnt_valid |-> gnt_cmd.op inside {op_read, op_write, op_add});

endmodule : mem_executor

`default_nettype wire

//--- logic/request_holder.sv
`timescale 1ns/1ns
`default_nettype none

// Holds one command per client until the arbiter grants it
module request_holder (
    input  wire                                                 clk,
    input  wire                                                 rst_n,
    input  wire  [mem_arb_pkg::num_clients-1:0]                 req_valid,
    input  wire  mem_arb_pkg::mem_cmd_t [mem_arb_pkg::num_clients-1:0] req_cmd,
    input  wire  [mem_arb_pkg::num_clients-1:0]                 gnt,
    output logic [mem_arb_pkg::num_clients-1:0]                 req,
    output logic                                                gnt_valid,
    output logic [mem_arb_pkg::client_w-1:0]                    gnt_client,
    output mem_arb_pkg::mem_cmd_t                               gnt_cmd
);

    import mem_arb_pkg::*;

    // One pending flag and one stored command per client
    logic     [num_clients-1:0] pending;
    mem_cmd_t [num_clients-1:0] cmd_q;

    // Strobe sets the flag, the grant cycle clears it
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pending <= '0;
        end
        else
        begin
            pending <= (pending & ~gnt) | req_valid;
        end
    end

    // Capture the command on its strobe
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < num_clients; i++)
        begin
            if (req_valid[i])
            begin
                cmd_q[i] <= req_cmd[i];
            end
        end
    end

    // Hide the client granted right now so it is not picked twice
    assign req = pending & ~gnt;

    assign gnt_valid = |gnt;

    // One-hot grant to client number
    always_comb
    begin
        gnt_client = '0;
        for (int i = 0; i < num_clients; i++)
        begin
            if (gnt[i])
            begin
                gnt_client = client_w'(i);
            end
        end
    end

    // Command of the granted client
    assign gnt_cmd = cmd_q[gnt_client];

    // A client waits for its response before posting again
    no_strobe_while_pending_a : assert property (@(posedge clk) disable iff (!rst_n)
        (req_valid & pending) == '0);

endmodule : request_holder

`default_nettype wire

//--- logic/round_robin_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

// Rotating-priority arbiter with a registered one-hot grant
module round_robin_arbiter #(
    parameter int clients = mem_arb_pkg::num_clients
) (
    input  wire                clk,
    input  wire                rst_n,
    input  wire  [clients-1:0] req,
    output logic [clients-1:0] gnt
);

    localparam int idx_w = $clog2(clients > 1 ? clients : 2);

    // ========================================================================
    // Priority state
    // ========================================================================

    // Bits below the last winner, empty until the first grant
    logic [clients-1:0] below_mask;
    // Everything except the last winner, all ones until the first grant
    logic [clients-1:0] excl_mask;

    // Masked request views
    logic [clients-1:0] req_below;
    logic [clients-1:0] req_excl;
    logic               multi_req;

    // Detector results
    logic [idx_w-1:0]   below_idx;
    logic               below_vld;
    logic [idx_w-1:0]   excl_idx;
    logic               excl_vld;

    // Winner of this cycle
    logic [idx_w-1:0]   winner;
    logic               win_vld;
    logic [clients-1:0] win_onehot;

    // ========================================================================
    // Winner selection
    // ========================================================================

    // More than one bit set
    assign multi_req = |(req & (req - 1'b1));

    // Lower-priority requesters relative to the last winner
    assign req_below = req & below_mask;

    // A lone requester wins even if it won last time
    assign req_excl = multi_req ? (req & excl_mask) : req;

    leading_one_detector #(
        .width (clients)
    ) below_lod_i (
        .data         (req_below),
        .leading_one  (below_idx),
        .trailing_one (),
        .valid        (below_vld)
    );

    leading_one_detector #(
        .width (clients)
    ) excl_lod_i (
        .data         (req_excl),
        .leading_one  (excl_idx),
        .trailing_one (),
        .valid        (excl_vld)
    );

    // Below-the-last-winner result first, otherwise start over from the top
    assign winner     = below_vld ? below_idx : excl_idx;
    assign win_vld    = below_vld | excl_vld;
    assign win_onehot = win_vld ? (clients'(1) << winner) : '0;

    // ========================================================================
    // Registers
    // ========================================================================

    // Priority moves only when somebody wins
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            below_mask <= '0;
            excl_mask  <= '1;
        end
        else if (win_vld)
        begin
            below_mask <= win_onehot - 1'b1;
            excl_mask  <= ~win_onehot;
        end
    end

    // One-cycle grant pulse
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            gnt <= '0;
        end
        else
        begin
            gnt <= win_onehot;
        end
    end

    // Never more than one client granted
    gnt_onehot_a : assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(gnt));

    // Each grant bit answers a request seen one edge earlier
    gnt_had_req_a : assert property (@(posedge clk) disable iff (!rst_n)
        (gnt & ~$past(req)) == '0);

endmodule : round_robin_arbiter

`default_nettype wire

//--- logic/leading_one_detector.sv
`timescale 1ns/1ns
`default_nettype none

// Finds the highest and lowest set bit of a vector
module leading_one_detector #(
    parameter int width = 4
) (
    input  wire  [width-1:0]                      data,
    output logic [$clog2(width > 1 ? width : 2)-1:0] leading_one,
    output logic [$clog2(width > 1 ? width : 2)-1:0] trailing_one,
    output logic                                  valid
);

    // At least one index bit, even for a single-bit vector
    localparam int idx_w = $clog2(width > 1 ? width : 2);

    // Any bit set at all
    assign valid = |data;

    // Scan upwards so the last hit is the highest set bit
    always_comb
    begin
        leading_one = '0;
        for (int i = 0; i < width; i++)
        begin
            if (data[i])
            begin
                leading_one = idx_w'(i);
            end
        end
    end

    // Scan downwards so the last hit is the lowest set bit
    always_comb
    begin
        trailing_one = '0;
        for (int i = width - 1; i >= 0; i--)
        begin
            if (data[i])
            begin
                trailing_one = idx_w'(i);
            end
        end
    end

    // Both indices read zero when nothing is set
    // Consumers must qualify them with valid

endmodule : leading_one_detector

`default_nettype wire

//--- logic/mem_arb_pkg.sv
`default_nettype none

// Shared constants and types for the arbitrated memory port
package mem_arb_pkg;

    // ========================================================================
    // Geometry
    // ========================================================================

    // Number of requesting clients
    localparam int num_clients = 4;
    // Bits needed to name one client
    localparam int client_w = $clog2(num_clients);

    // Memory words and address width
    localparam int mem_depth = 16;
    localparam int addr_w = $clog2(mem_depth);

    // Width of one data word
    localparam int data_w = 32;

    // ========================================================================
    // Commands and responses
    // ========================================================================

    // Read returns the word
    // Write stores data and returns the old word
    // Add stores word plus data and returns the new word
    typedef enum logic [1:0] {
        op_read  = 2'd0,
        op_write = 2'd1,
        op_add   = 2'd2
    } mem_op_e;

    // One client command as held until granted
    typedef struct packed {
        mem_op_e           op;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] data;
    } mem_cmd_t;

    // Response tagged with the client that issued the command
    typedef struct packed {
        logic [client_w-1:0] client;
        logic [data_w-1:0]   rdata;
    } mem_rsp_t;

endpackage : mem_arb_pkg

`default_nettype wire
